// ==== pc_bus_pkg.sv ====
// Shared bus widths, request struct, memory regions and I/O port map for the PC bus fabric

package pc_bus_pkg;

	// ======================================================================
	// Bus widths
	// ======================================================================

	localparam int ADDR_W = 19; // Word address, byte address bits 19..1
	localparam int DATA_W = 16; // One bus word

	typedef logic [ADDR_W:1]   word_addr_t; // Byte address without bit 0
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [1:0]        bytesel_t;   // Bit 1 high byte, bit 0 low byte

	// ======================================================================
	// Memory request
	// ======================================================================

	// One access as seen on a memory port
	typedef struct packed {
		word_addr_t addr;
		data_t      wdata;
		logic       wr_en;
		bytesel_t   bytesel;
	} mem_req_t;

	// Target region of an arbitrated access
	typedef enum logic [1:0] {
		REGION_EXT   = 2'd0, // External memory
		REGION_BIOS  = 2'd1, // Boot ROM window at the top of the map
		REGION_VIDEO = 2'd2  // Text and graphics frame buffers
	} mem_region_t;

	// ======================================================================
	// I/O port map
	// ======================================================================

	localparam logic [15:0] IO_LEDS_PORT      = 16'hfffe; // LED status
	localparam logic [15:0] IO_BIOS_CTRL_PORT = 16'hffec; // Boot ROM enable

endpackage

// ==== mem_arbiter.sv ====
// Two-master to one-target memory arbiter with held grant and alternating tie priority
`timescale 1ns/1ps

module mem_arbiter (
	input  logic                 sys_clk,
	input  logic                 reset,

	// Port a
	input  logic                 a_access,
	input  pc_bus_pkg::mem_req_t a_req,
	output logic                 a_ack,
	output pc_bus_pkg::data_t    a_rdata,

	// Port b
	input  logic                 b_access,
	input  pc_bus_pkg::mem_req_t b_req,
	output logic                 b_ack,
	output pc_bus_pkg::data_t    b_rdata,

	// Shared target port
	output logic                 q_access,
	output pc_bus_pkg::mem_req_t q_req,
	input  logic                 q_ack,
	input  pc_bus_pkg::data_t    q_rdata
);

	import pc_bus_pkg::*;

	logic grant_a;  // Port a owns the target
	logic grant_b;  // Port b owns the target
	logic last_b;   // Port b was served last
	logic idle;

	assign idle = !grant_a && !grant_b;

	// ======================================================================
	// Grant state
	// ======================================================================

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			grant_a <= 1'b0;
			grant_b <= 1'b0;
			last_b  <= 1'b1; // Port a wins the first tie
		end else if (idle) begin
			// Pick a winner, tie goes to the port not served last
			if (a_access && (!b_access || last_b)) begin
				grant_a <= 1'b1;
				last_b  <= 1'b0;
			end else if (b_access) begin
				grant_b <= 1'b1;
				last_b  <= 1'b1;
			end
		end else if (q_ack) begin
			// Transfer done, back to idle for one cycle
			grant_a <= 1'b0;
			grant_b <= 1'b0;
		end
	end

	// ======================================================================
	// Request forward and response return
	// ======================================================================

	assign q_access = grant_a | grant_b;
	assign q_req    = grant_b ? b_req : a_req; // Held stable by the owner

	// Ack straight through to the owner only
	assign a_ack = grant_a & q_ack;
	assign b_ack = grant_b & q_ack;

	// Read data steered, other port sees zero
	assign a_rdata = grant_a ? q_rdata : '0;
	assign b_rdata = grant_b ? q_rdata : '0;

endmodule

// ==== mem_region_decoder.sv ====
// Memory region classifier for boot ROM, video windows and external memory
`timescale 1ns/1ps

module mem_region_decoder (
	input  pc_bus_pkg::word_addr_t  addr,
	input  logic                    bios_enabled,
	output pc_bus_pkg::mem_region_t region
);

	import pc_bus_pkg::*;

	logic [19:0] byte_addr;
	logic        in_bios;
	logic        in_text;
	logic        in_gfx;

	assign byte_addr = {addr, 1'b0};

	// ======================================================================
	// Window compares on the upper address bits
	// ======================================================================

	// FC000..FFFFF, 16 KiB boot ROM
	assign in_bios = (byte_addr[19:14] == 6'b1111_11);

	// B8000..BBFFF, text frame buffer
	assign in_text = (byte_addr[19:14] == 6'b1011_10);

	// A0000..AFFFF, graphics frame buffer
	assign in_gfx  = (byte_addr[19:16] == 4'ha);

	always_comb begin
		region = REGION_EXT; // Everything else is external memory
		if (bios_enabled && in_bios) begin
			region = REGION_BIOS;
		end else if (in_text || in_gfx) begin
			region = REGION_VIDEO;
		end
	end

endmodule

// ==== bios_control_reg.sv ====
// Boot ROM enable register on the I/O bus
`timescale 1ns/1ps

module bios_control_reg (
	input  logic              sys_clk,
	input  logic              reset,
	input  logic              cs,
	input  logic              wr_en,
	input  pc_bus_pkg::data_t wdata,
	output logic              ack,
	output pc_bus_pkg::data_t rdata,
	output logic              bios_enabled
);

	import pc_bus_pkg::*;

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			ack          <= 1'b0;
			bios_enabled <= 1'b1; // Boot from ROM
		end else begin
			ack <= cs & ~ack; // Single cycle ack
			if (cs && wr_en && !ack) begin
				bios_enabled <= wdata[0]; // Lands with the ack edge
			end
		end
	end

	// Enable bit in bit 0, zero outside the ack cycle
	assign rdata = ack ? {{(DATA_W-1){1'b0}}, bios_enabled} : '0;

endmodule

// ==== data_bus_router.sv ====
// Data bus splitter into memory and I/O cycles with port decode and default I/O responder
`timescale 1ns/1ps

module data_bus_router (
	input  logic                 sys_clk,
	input  logic                 reset,

	// Processor data bus
	input  logic                 data_access,
	input  pc_bus_pkg::mem_req_t data_req,
	input  logic                 data_io,
	output logic                 data_ack,
	output pc_bus_pkg::data_t    data_rdata,

	// Toward the arbiter
	output logic                 mem_port_access,
	input  logic                 mem_port_ack,
	input  pc_bus_pkg::data_t    mem_port_rdata,

	// I/O chip selects
	output logic                 leds_cs,
	output logic                 bios_ctrl_cs,

	// I/O register responses
	input  logic                 leds_ack,
	input  pc_bus_pkg::data_t    leds_rdata,
	input  logic                 bios_ctrl_ack,
	input  pc_bus_pkg::data_t    bios_ctrl_rdata
);

	import pc_bus_pkg::*;

	logic [15:0] io_port;
	logic        io_cycle;
	logic        default_cs;  // Unmapped port
	logic        default_ack;
	data_t       io_rdata;

	// ======================================================================
	// Cycle split
	// ======================================================================

	assign io_cycle        = data_access & data_io;
	assign mem_port_access = data_access & ~data_io; // I/O never hits memory

	assign io_port = {data_req.addr[15:1], 1'b0}; // Even port address

	// ======================================================================
	// I/O port decode
	// ======================================================================

	always_comb begin
		leds_cs      = 1'b0;
		bios_ctrl_cs = 1'b0;
		default_cs   = 1'b0;
		if (io_cycle) begin
			case (io_port)
				IO_LEDS_PORT:      leds_cs      = 1'b1;
				IO_BIOS_CTRL_PORT: bios_ctrl_cs = 1'b1;
				default:           default_cs   = 1'b1;
			endcase
		end
	end

	// Default responder, acks and reads as zero
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			default_ack <= 1'b0;
		end else begin
			default_ack <= default_cs & ~default_ack;
		end
	end

	// ======================================================================
	// Response merge
	// ======================================================================

	assign io_rdata = leds_rdata | bios_ctrl_rdata; // Each zero when idle

	assign data_ack   = mem_port_ack | leds_ack | bios_ctrl_ack | default_ack;
	assign data_rdata = data_io ? io_rdata : mem_port_rdata;

endmodule

// ==== led_blinker.sv ====
// LED status register with blink and pause sequencer for the user LED
`timescale 1ns/1ps

module led_blinker #(
	parameter int BLINK_CYCLES = 25_000_000,
	parameter int PAUSE_CYCLES = 25_000_000
) (
	input  logic              sys_clk,
	input  logic              reset,
	input  logic              cs,
	input  logic              wr_en,
	input  pc_bus_pkg::data_t wdata,
	output logic              ack,
	output pc_bus_pkg::data_t rdata,
	output logic              led_user
);

	import pc_bus_pkg::*;

	// Counter wide enough for the longer phase
	localparam int MAX_CYCLES = (BLINK_CYCLES > PAUSE_CYCLES) ? BLINK_CYCLES : PAUSE_CYCLES;
	localparam int CNT_W      = $clog2(MAX_CYCLES) + 1;

	localparam logic [CNT_W-1:0] BLINK_LAST = CNT_W'(BLINK_CYCLES - 1);
	localparam logic [CNT_W-1:0] PAUSE_LAST = CNT_W'(PAUSE_CYCLES - 1);

	logic [7:0]       status;   // Blink divider s, zero when quiet
	logic [7:0]       mod_cnt;  // Phase counter modulo s
	logic [CNT_W-1:0] cnt;      // Phase counter
	logic             in_pause; // Low in blink phase
	logic             wr_hit;

	assign wr_hit = cs & wr_en & ~ack;

	// ======================================================================
	// Status register and sequencer
	// ======================================================================

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			ack      <= 1'b0;
			status   <= 8'd0;
			mod_cnt  <= 8'd0;
			cnt      <= '0;
			in_pause <= 1'b0;
			led_user <= 1'b0;
		end else begin
			ack <= cs & ~ack;
			if (status == 8'd0) begin
				// Quiet, hold everything at the start of a blink phase
				mod_cnt  <= 8'd0;
				cnt      <= '0;
				in_pause <= 1'b0;
				led_user <= 1'b0;
			end else if (!in_pause) begin
				led_user <= (mod_cnt == 8'd0); // Every s-th count
				mod_cnt  <= (mod_cnt >= status - 8'd1) ? 8'd0 : mod_cnt + 8'd1;
				if (cnt == BLINK_LAST) begin
					cnt      <= '0;
					in_pause <= 1'b1;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end else begin
				led_user <= 1'b0; // Dark during the pause
				if (cnt == PAUSE_LAST) begin
					cnt      <= '0;
					in_pause <= 1'b0;
					status   <= 8'd0; // Sequence done
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
			// Bus write wins over the self clear
			if (wr_hit) begin
				status <= wdata[7:0];
			end
		end
	end

	assign rdata = ack ? {8'd0, status} : '0;

endmodule

// ==== pc_bus_top.sv ====
// System bus fabric top linking arbiter, region decode, I/O routing and LED blinker
`timescale 1ns/1ps

module pc_bus_top #(
	parameter int BLINK_CYCLES = 25_000_000,
	parameter int PAUSE_CYCLES = 25_000_000
) (
	input  logic                    sys_clk,
	input  logic                    reset,

	// Instruction bus
	input  logic                    instr_access,
	input  pc_bus_pkg::word_addr_t  instr_addr,
	output logic                    instr_ack,
	output pc_bus_pkg::data_t       instr_rdata,

	// Data bus
	input  logic                    data_access,
	input  pc_bus_pkg::mem_req_t    data_req,
	input  logic                    data_io,
	output logic                    data_ack,
	output pc_bus_pkg::data_t       data_rdata,

	// Memory port
	output logic                    mem_access,
	output pc_bus_pkg::mem_req_t    mem_req,
	output pc_bus_pkg::mem_region_t mem_region,
	input  logic                    mem_ack,
	input  pc_bus_pkg::data_t       mem_rdata,

	output logic                    led_user
);

	import pc_bus_pkg::*;

	mem_req_t instr_req;       // Fetch as a read-only request
	logic     data_mem_access;
	logic     data_mem_ack;
	data_t    data_mem_rdata;
	logic     leds_cs;
	logic     leds_ack;
	data_t    leds_rdata;
	logic     bios_ctrl_cs;
	logic     bios_ctrl_ack;
	data_t    bios_ctrl_rdata;
	logic     bios_enabled;

	assign instr_req = '{addr: instr_addr, wdata: '0, wr_en: 1'b0, bytesel: 2'b11};

	// ======================================================================
	// Memory side
	// ======================================================================

	mem_arbiter u_arbiter (
		.sys_clk (sys_clk),        .reset   (reset),
		.a_access(instr_access),   .a_req   (instr_req),
		.a_ack   (instr_ack),      .a_rdata (instr_rdata),
		.b_access(data_mem_access), .b_req  (data_req),
		.b_ack   (data_mem_ack),   .b_rdata (data_mem_rdata),
		.q_access(mem_access),     .q_req   (mem_req),
		.q_ack   (mem_ack),        .q_rdata (mem_rdata)
	);

	mem_region_decoder u_region (
		.addr(mem_req.addr), .bios_enabled(bios_enabled), .region(mem_region)
	);

	// ======================================================================
	// I/O side
	// ======================================================================

	data_bus_router u_router (
		.sys_clk(sys_clk), .reset(reset),
		.data_access(data_access), .data_req(data_req), .data_io(data_io),
		.data_ack(data_ack), .data_rdata(data_rdata),
		.mem_port_access(data_mem_access), .mem_port_ack(data_mem_ack),
		.mem_port_rdata(data_mem_rdata),
		.leds_cs(leds_cs), .bios_ctrl_cs(bios_ctrl_cs),
		.leds_ack(leds_ack), .leds_rdata(leds_rdata),
		.bios_ctrl_ack(bios_ctrl_ack), .bios_ctrl_rdata(bios_ctrl_rdata)
	);

	bios_control_reg u_bios_ctrl (
		.sys_clk(sys_clk), .reset(reset), .cs(bios_ctrl_cs),
		.wr_en(data_req.wr_en), .wdata(data_req.wdata),
		.ack(bios_ctrl_ack), .rdata(bios_ctrl_rdata), .bios_enabled(bios_enabled)
	);

	led_blinker #(
		.BLINK_CYCLES(BLINK_CYCLES),
		.PAUSE_CYCLES(PAUSE_CYCLES)
	) u_blinker (
		.sys_clk(sys_clk), .reset(reset), .cs(leds_cs),
		.wr_en(data_req.wr_en), .wdata(data_req.wdata),
		.ack(leds_ack), .rdata(leds_rdata), .led_user(led_user)
	);

endmodule

// ==== pc_bus_chk.sv ====
// Bus protocol and LED assertions bound into the fabric top level
`timescale 1ns/1ps

module pc_bus_chk (
	input logic                 sys_clk,
	input logic                 reset,
	input logic                 mem_access,
	input pc_bus_pkg::mem_req_t mem_req,
	input logic                 mem_ack,
	input logic                 instr_ack,
	input logic                 data_mem_ack,
	input logic                 data_access,
	input logic                 data_io,
	input logic                 data_ack,
	input logic                 led_user,
	input logic [7:0]           led_status
);

	int fails = 0; // Failed assertion count

	// Grant held with a steady request until the target acks
	assert property (@(posedge sys_clk) disable iff (reset)
		mem_access && !mem_ack |=> mem_access && $stable(mem_req))
	else begin
		$error("memory request dropped or changed before ack");
		fails++;
	end

	// Each target ack reaches exactly one owner
	assert property (@(posedge sys_clk) disable iff (reset)
		mem_ack |-> (instr_ack ^ data_mem_ack))
	else begin
		$error("target ack not routed to exactly one bus");
		fails++;
	end

	// Quiet LED while status is zero
	assert property (@(posedge sys_clk) disable iff (reset) led_status == 8'd0 |-> !led_user)
	else begin
		$error("LED lit with zero status");
		fails++;
	end

	// I/O ack exactly one cycle after access rises
	assert property (@(posedge sys_clk) disable iff (reset)
		$rose(data_access && data_io) |-> !data_ack ##1 data_ack)
	else begin
		$error("I/O ack not one cycle after access");
		fails++;
	end

endmodule

bind pc_bus_top pc_bus_chk chk0 (
	.sys_clk(sys_clk), .reset(reset), .mem_access(mem_access), .mem_req(mem_req),
	.mem_ack(mem_ack), .instr_ack(instr_ack), .data_mem_ack(data_mem_ack),
	.data_access(data_access), .data_io(data_io), .data_ack(data_ack),
	.led_user(led_user), .led_status(u_blinker.status)
);

// ==== tb_pc_bus.sv ====
// Testbench for the PC bus fabric with memory responder, reference models and checks
`timescale 1ns/1ps

module tb_pc_bus;

	import pc_bus_pkg::*;

	localparam int BLINK = 40;
	localparam int PAUSE = 20;
	localparam int LIMIT = 200; // Cycles per wait

	logic        sys_clk = 1'b0;
	logic        reset;
	logic        instr_access;
	word_addr_t  instr_addr;
	logic        instr_ack;
	data_t       instr_rdata;
	logic        data_access;
	mem_req_t    data_req;
	logic        data_io;
	logic        data_ack;
	data_t       data_rdata;
	logic        mem_access;
	mem_req_t    mem_req;
	mem_region_t mem_region;
	logic        mem_ack = 1'b0;
	data_t       mem_rdata = '0;
	logic        led_user;

	int       seed = 26;
	int       errors = 0;
	int       checks = 0;
	bit       timed_out = 1'b0;
	bit       bios_ref = 1'b1;  // Expected boot ROM enable
	int       led_highs = 0;    // LED high cycles so far
	bit       busy = 1'b0;      // Responder holds a request
	int       delay = 0;
	mem_req_t last_wr = '0;     // Last write seen by the responder
	int       blink_vals [3] = '{1, 3, 7};
	logic [19:0] edges [12] = '{20'hfc000, 20'hfbffe, 20'hffffe, 20'hb8000, 20'hb7ffe,
		20'hbbffe, 20'hbc000, 20'ha0000, 20'h9fffe, 20'hafffe, 20'hb0000, 20'h00000};

	pc_bus_top #(.BLINK_CYCLES(BLINK), .PAUSE_CYCLES(PAUSE)) dut0 (.*);

	always #4 sys_clk = ~sys_clk; // 8 ns period

	// ======================================================================
	// Reference models
	// ======================================================================

	// Memory contents with every address bit folded in
	function automatic data_t mem_word(word_addr_t a);
		return a[16:1] ^ {a[19:17], 13'h0a5c};
	endfunction

	function automatic mem_region_t exp_region(word_addr_t a, bit bios_en);
		logic [19:0] b;
		b = {a, 1'b0};
		if (bios_en && b >= 20'hfc000) return REGION_BIOS;
		if ((b >= 20'hb8000 && b <= 20'hbbfff) || (b >= 20'ha0000 && b <= 20'haffff))
			return REGION_VIDEO;
		return REGION_EXT;
	endfunction

	function automatic int exp_highs(int s);
		return (BLINK + s - 1) / s; // ceil(BLINK / s)
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	// ======================================================================
	// Memory responder with 0 to 3 wait cycles
	// ======================================================================

	always @(posedge sys_clk) begin
		if (reset) begin
			mem_ack <= 1'b0;
			busy    <= 1'b0;
		end else if (mem_ack) begin
			mem_ack <= 1'b0; // One cycle ack
			busy    <= 1'b0;
		end else if (mem_access && !busy) begin
			busy  <= 1'b1;
			delay <= $random(seed) & 3;
		end else if (busy && delay != 0) begin
			delay <= delay - 1;
		end else if (busy) begin
			mem_ack   <= 1'b1;
			mem_rdata <= mem_req.wr_en ? 16'h0000 : mem_word(mem_req.addr);
			if (mem_req.wr_en) last_wr <= mem_req;
			check("mem_region", mem_region, exp_region(mem_req.addr, bios_ref));
		end
	end

	always @(negedge sys_clk) if (led_user) led_highs++;

	// ======================================================================
	// Bus masters
	// ======================================================================

	task automatic data_xfer(input bit io, input word_addr_t addr, input bit wr,
		input data_t wdata, input bytesel_t bs, output data_t rdata);
		int n = 0;
		int others = 0; // Fetches served while waiting
		bit hit = 1'b0;
		bit saw_mem = 1'b0;
		@(posedge sys_clk);
		data_access <= 1'b1;
		data_io     <= io;
		data_req    <= '{addr: addr, wdata: wdata, wr_en: wr, bytesel: bs};
		while (!hit && !timed_out) begin
			@(negedge sys_clk);
			hit   = data_ack;
			rdata = data_rdata;
			if (instr_ack) others++;
			if (mem_access) saw_mem = 1'b1;
			n++;
			if (!hit && n >= LIMIT) begin
				timed_out = 1'b1;
				$display("Timeout: no data bus ack at %0t", $time);
			end
		end
		@(posedge sys_clk);
		data_access <= 1'b0;
		if (io) check("io_mem_access", saw_mem, 0);
		else check("data_wait_xfers", others > 1, 0);
		if (!io && !wr) check("data_rdata", rdata, mem_word(addr));
		if (!io && wr) begin
			check("mem_req.addr", last_wr.addr, addr);
			check("mem_req.wdata", last_wr.wdata, wdata);
			check("mem_req.bytesel", last_wr.bytesel, bs);
		end
	endtask

	// Access stays high so that the next fetch follows in the cycle after the ack
	task automatic fetch(input word_addr_t addr);
		int n = 0;
		int others = 0; // Data transfers served while waiting
		bit hit = 1'b0;
		data_t rdata;
		@(posedge sys_clk);
		instr_access <= 1'b1;
		instr_addr   <= addr;
		while (!hit && !timed_out) begin
			@(negedge sys_clk);
			hit   = instr_ack;
			rdata = instr_rdata;
			if (data_ack) others++;
			n++;
			if (!hit && n >= LIMIT) begin
				timed_out = 1'b1;
				$display("Timeout: no instruction bus ack at %0t", $time);
			end
		end
		check("instr_rdata", rdata, mem_word(addr));
		check("instr_wait_xfers", others > 1, 0);
	endtask

	task automatic read_port(input logic [15:0] port, input data_t exp);
		data_t rd;
		data_xfer(1'b1, word_addr_t'(port >> 1), 1'b0, '0, 2'b11, rd);
		check("io_rdata", rd, exp);
	endtask

	task automatic write_port(input logic [15:0] port, input data_t val);
		data_t rd;
		data_xfer(1'b1, word_addr_t'(port >> 1), 1'b1, val, 2'b11, rd);
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		data_t rd;
		int    n;
		int    start;
		bit    done;
		reset        = 1'b1;
		instr_access = 1'b0;
		instr_addr   = '0;
		data_access  = 1'b0;
		data_req     = '0;
		data_io      = 1'b0;
		repeat (5) @(posedge sys_clk);
		reset <= 1'b0;

		@(negedge sys_clk); // Reset state
		check("mem_access", mem_access, 0);
		check("led_user", led_user, 0);
		read_port(IO_BIOS_CTRL_PORT, 16'h0001);
		read_port(IO_LEDS_PORT, 16'h0000);

		foreach (edges[i]) data_xfer(1'b0, word_addr_t'(edges[i] >> 1), 1'b0, '0, 2'b11, rd);
		repeat (30) begin
			data_xfer(1'b0, word_addr_t'($random(seed)), 1'($random(seed)),
				data_t'($random(seed)), bytesel_t'($random(seed)), rd);
		end

		write_port(IO_BIOS_CTRL_PORT, 16'h0000); // ROM off
		bios_ref = 1'b0;
		read_port(IO_BIOS_CTRL_PORT, 16'h0000);
		data_xfer(1'b0, word_addr_t'(20'hfc000 >> 1), 1'b0, '0, 2'b11, rd);
		data_xfer(1'b0, word_addr_t'(20'hffffe >> 1), 1'b0, '0, 2'b11, rd);
		write_port(IO_BIOS_CTRL_PORT, 16'h0001);
		bios_ref = 1'b1;
		data_xfer(1'b0, word_addr_t'(20'hfc000 >> 1), 1'b0, '0, 2'b11, rd);
		data_xfer(1'b0, word_addr_t'(20'hffffe >> 1), 1'b0, '0, 2'b11, rd);

		fork // Both masters at once
			begin
				repeat (20) fetch(word_addr_t'($random(seed)));
				@(posedge sys_clk);
				instr_access <= 1'b0; // Instruction bus quiet again
			end
			repeat (20) data_xfer(1'b0, word_addr_t'($random(seed)), 1'($random(seed)),
				data_t'($random(seed)), 2'b11, rd);
		join

		read_port(16'h0060, 16'h0000); // Unmapped ports
		read_port(16'h03f8, 16'h0000);
		write_port(16'h0080, 16'hbeef);
		read_port(16'h0080, 16'h0000);
		repeat (4) read_port({1'b0, 15'($random(seed))}, 16'h0000);

		foreach (blink_vals[k]) begin
			start = led_highs;
			write_port(IO_LEDS_PORT, data_t'(blink_vals[k]));
			n    = 0;
			done = 1'b0;
			while (!done && !timed_out) begin
				data_xfer(1'b1, word_addr_t'(IO_LEDS_PORT >> 1), 1'b0, '0, 2'b11, rd);
				done = (rd == 16'h0000);
				n++;
				if (!done && n >= LIMIT) begin
					timed_out = 1'b1;
					$display("Timeout: LED status never cleared");
				end
			end
			check("led_highs", led_highs - start, exp_highs(blink_vals[k]));
		end
		start = led_highs;
		repeat (2 * (BLINK + PAUSE)) @(posedge sys_clk);
		check("led_quiet", led_highs, start); // No stray blinks

		errors += dut0.chk0.fails;
		$display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timed_out);
		if (errors == 0 && !timed_out)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== vlog.f ====
pc_bus_pkg.sv
mem_arbiter.sv
mem_region_decoder.sv
bios_control_reg.sv
data_bus_router.sv
led_blinker.sv
pc_bus_top.sv
pc_bus_chk.sv
tb_pc_bus.sv

// ==== Makefile ====
TOP = tb_pc_bus
RTL = pc_bus_pkg.sv mem_arbiter.sv mem_region_decoder.sv bios_control_reg.sv \
	data_bus_router.sv led_blinker.sv pc_bus_top.sv

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

lint:
	verilator --lint-only -Wall $(RTL) --top-module pc_bus_top
	verilator --lint-only --timing --assert -Wall -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir
